// ==== src/ros2_eth_defs.svh ====
`ifndef ROS2_ETH_DEFS_SVH
`define ROS2_ETH_DEFS_SVH

// ######################################################################
// queue sizing, power of two, 4 or more
// ######################################################################
`define ROS2_ETH_TX_DEPTH 16
`define ROS2_ETH_RX_DEPTH 16

// ######################################################################
// ipv4 and core framing constants
// ######################################################################
`define ROS2_ETH_IP_HDR_LEN 20
`define ROS2_ETH_PROTO_UDP 17
`define ROS2_ETH_DEFAULT_TTL 64

// address (4 bytes) plus payload length (2 bytes), msb first
`define ROS2_ETH_FRAME_HDR_LEN 6

`endif

// ==== src/ros2_eth_pkg.sv ====
package ros2_eth_pkg;

  // header handed to the ip stack for transmit
  typedef struct packed {
    logic [31:0] dest_ip;
    logic [31:0] source_ip;
    logic [15:0] length;     // ip header plus payload
    logic [7:0]  protocol;
    logic [7:0]  ttl;
    logic [5:0]  dscp;
    logic [1:0]  ecn;
  } ip_tx_hdr_t;

  // header delivered by the ip stack on receive
  typedef struct packed {
    logic [31:0] source_ip;
    logic [31:0] dest_ip;
    logic [15:0] length;     // ip header plus payload
    logic [7:0]  protocol;
    logic [7:0]  ttl;
  } ip_rx_hdr_t;

  // one payload byte of a packet
  typedef struct packed {
    logic [7:0] data;
    logic       last;        // final byte of the packet
  } ip_beat_t;

  // app data ownership
  typedef enum logic [1:0] {
    GRANT_NONE = 2'b00,
    GRANT_IP   = 2'b01,
    GRANT_CPU  = 2'b10
  } grant_state_t;

endpackage

// ==== src/byte_queue.sv ====
module byte_queue #(
  parameter int DEPTH = 16
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_wr_en,
  input  logic [7:0] i_din,
  output logic       o_full,
  input  logic       i_rd_en,
  output logic [7:0] o_dout,
  output logic       o_empty
);

  localparam int AW = $clog2(DEPTH);

  logic [7:0]    mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;     // one extra bit to tell full from empty
  logic          do_wr;
  logic          do_rd;

  assign o_full  = (count == (AW+1)'(DEPTH));
  assign o_empty = (count == '0);
  assign do_wr   = i_wr_en & ~o_full;   // writes to a full queue are dropped
  assign do_rd   = i_rd_en & ~o_empty;

  // show-ahead, head entry is always on the output
  assign o_dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= i_din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== src/ros2_eth_tx_adapter.sv ====
`include "ros2_eth_defs.svh"

module ros2_eth_tx_adapter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_enable,
  input  logic [31:0]              i_local_ip,
  input  logic [7:0]               i_din,
  input  logic                     i_din_empty,
  output logic                     o_din_rd_en,
  output ros2_eth_pkg::ip_tx_hdr_t o_tx_hdr,
  output logic                     o_tx_hdr_valid,
  input  logic                     i_tx_hdr_ready,
  output ros2_eth_pkg::ip_beat_t   o_tx_payload,
  output logic                     o_tx_payload_valid,
  input  logic                     i_tx_payload_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PREFIX,
    ST_HEADER,
    ST_PAYLOAD
  } state_t;

  state_t      state;
  logic [2:0]  byte_idx;
  logic [47:0] prefix;      // dest ip then payload length
  logic [15:0] remain;      // payload bytes still to send
  logic        pop_prefix;
  logic        beat_done;

  assign pop_prefix  = (state == ST_PREFIX) & ~i_din_empty;
  assign beat_done   = o_tx_payload_valid & i_tx_payload_ready;
  assign o_din_rd_en = pop_prefix | beat_done;

  // ######################################################################
  // ip side outputs
  // ######################################################################
  always_comb begin
    o_tx_hdr.dest_ip   = prefix[47:16];
    o_tx_hdr.source_ip = i_local_ip;
    o_tx_hdr.length    = prefix[15:0] + 16'(`ROS2_ETH_IP_HDR_LEN);
    o_tx_hdr.protocol  = 8'(`ROS2_ETH_PROTO_UDP);
    o_tx_hdr.ttl       = 8'(`ROS2_ETH_DEFAULT_TTL);
    o_tx_hdr.dscp      = '0;
    o_tx_hdr.ecn       = '0;
  end

  assign o_tx_hdr_valid = (state == ST_HEADER);

  always_comb begin
    o_tx_payload.data = i_din;
    o_tx_payload.last = (remain == 16'd1);
  end

  assign o_tx_payload_valid = (state == ST_PAYLOAD) & ~i_din_empty;

  // prefix bytes arrive msb first
  always_ff @(posedge clk) begin
    if (pop_prefix) begin
      prefix <= {prefix[39:0], i_din};
    end
  end

  // ######################################################################
  // frame FSM
  // ######################################################################
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      byte_idx <= '0;
      remain   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          byte_idx <= '0;
          if (i_enable && !i_din_empty) begin
            state <= ST_PREFIX;   // only start new frames while enabled
          end
        end
        ST_PREFIX: begin
          if (pop_prefix) begin
            byte_idx <= byte_idx + 3'd1;
            if (byte_idx == 3'(`ROS2_ETH_FRAME_HDR_LEN - 1)) begin
              state <= ST_HEADER;
            end
          end
        end
        ST_HEADER: begin
          if (i_tx_hdr_ready) begin
            remain <= prefix[15:0];
            state  <= (prefix[15:0] == '0) ? ST_IDLE : ST_PAYLOAD;   // empty frame
          end
        end
        ST_PAYLOAD: begin
          if (beat_done) begin
            remain <= remain - 16'd1;
            if (o_tx_payload.last) begin
              state <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== src/ros2_eth_rx_adapter.sv ====
`include "ros2_eth_defs.svh"

module ros2_eth_rx_adapter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_enable,
  input  ros2_eth_pkg::ip_rx_hdr_t i_rx_hdr,
  input  logic                     i_rx_hdr_valid,
  output logic                     o_rx_hdr_ready,
  input  ros2_eth_pkg::ip_beat_t   i_rx_payload,
  input  logic                     i_rx_payload_valid,
  output logic                     o_rx_payload_ready,
  output logic [7:0]               o_dout,
  input  logic                     i_dout_full,
  output logic                     o_dout_wr_en
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PREFIX,
    ST_PAYLOAD,
    ST_DROP
  } state_t;

  state_t      state;
  logic [2:0]  byte_idx;
  logic [47:0] prefix;      // source ip then payload length
  logic        hdr_take;
  logic        is_udp;
  logic        push_prefix;
  logic        beat_done;

  assign o_rx_hdr_ready = (state == ST_IDLE) & i_enable;
  assign hdr_take       = o_rx_hdr_ready & i_rx_hdr_valid;
  assign is_udp         = (i_rx_hdr.protocol == 8'(`ROS2_ETH_PROTO_UDP));

  assign push_prefix = (state == ST_PREFIX) & ~i_dout_full;
  assign beat_done   = o_rx_payload_ready & i_rx_payload_valid;

  // ######################################################################
  // queue write side
  // ######################################################################
  always_comb begin
    case (state)
      ST_PAYLOAD: o_rx_payload_ready = ~i_dout_full;
      ST_DROP:    o_rx_payload_ready = 1'b1;   // sink everything up to last
      default:    o_rx_payload_ready = 1'b0;
    endcase
  end

  assign o_dout_wr_en = push_prefix | ((state == ST_PAYLOAD) & beat_done);
  assign o_dout       = (state == ST_PREFIX) ? prefix[47:40] : i_rx_payload.data;

  // header latch, then shifted out msb first
  always_ff @(posedge clk) begin
    if (hdr_take) begin
      prefix <= {i_rx_hdr.source_ip,
                 i_rx_hdr.length - 16'(`ROS2_ETH_IP_HDR_LEN)};
    end else if (push_prefix) begin
      prefix <= {prefix[39:0], 8'h00};
    end
  end

  // ######################################################################
  // packet FSM
  // ######################################################################
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      byte_idx <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          byte_idx <= '0;
          if (hdr_take) begin
            state <= is_udp ? ST_PREFIX : ST_DROP;
          end
        end
        ST_PREFIX: begin
          if (push_prefix) begin
            byte_idx <= byte_idx + 3'd1;
            if (byte_idx == 3'(`ROS2_ETH_FRAME_HDR_LEN - 1)) begin
              state <= ST_PAYLOAD;
            end
          end
        end
        ST_PAYLOAD, ST_DROP: begin
          if (beat_done && i_rx_payload.last) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== src/buffer_grant_ctrl.sv ====
module buffer_grant_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic i_enable,
  input  logic i_app_data_ip_req,
  input  logic i_app_data_ip_rel,
  input  logic i_app_data_cpu_req,
  input  logic i_app_data_cpu_rel,
  output logic o_app_data_ip_grant,
  output logic o_app_data_cpu_grant,
  input  logic i_app_rx_ip_rel,
  input  logic i_app_rx_cpu_rel,
  output logic o_app_rx_ip_grant,
  output logic o_app_rx_cpu_grant
);

  ros2_eth_pkg::grant_state_t data_state;
  logic                       rx_cpu_owner;   // 0 core holds rx data, 1 cpu

  assign o_app_data_ip_grant  = i_enable & (data_state == ros2_eth_pkg::GRANT_IP);
  assign o_app_data_cpu_grant = i_enable & (data_state == ros2_eth_pkg::GRANT_CPU);
  assign o_app_rx_ip_grant    = i_enable & ~rx_cpu_owner;
  assign o_app_rx_cpu_grant   = i_enable & rx_cpu_owner;

  // ######################################################################
  // app data arbiter, core wins ties
  // ######################################################################
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_state <= ros2_eth_pkg::GRANT_NONE;
    end else begin
      case (data_state)
        ros2_eth_pkg::GRANT_NONE: begin
          if (i_app_data_ip_req) begin
            data_state <= ros2_eth_pkg::GRANT_IP;
          end else if (i_app_data_cpu_req) begin
            data_state <= ros2_eth_pkg::GRANT_CPU;
          end
        end
        ros2_eth_pkg::GRANT_IP: begin
          if (i_app_data_ip_rel) data_state <= ros2_eth_pkg::GRANT_NONE;
        end
        ros2_eth_pkg::GRANT_CPU: begin
          if (i_app_data_cpu_rel) data_state <= ros2_eth_pkg::GRANT_NONE;
        end
        default: data_state <= ros2_eth_pkg::GRANT_NONE;
      endcase
    end
  end

  // rx data buffer ping-pongs on the holder's release
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_cpu_owner <= 1'b0;
    end else if (!rx_cpu_owner && i_app_rx_ip_rel) begin
      rx_cpu_owner <= 1'b1;
    end else if (rx_cpu_owner && i_app_rx_cpu_rel) begin
      rx_cpu_owner <= 1'b0;
    end
  end

endmodule

// ==== src/ros2_eth_bridge.sv ====
`include "ros2_eth_defs.svh"

module ros2_eth_bridge (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_ether_en,
  input  logic [31:0]              i_local_ip,
  // core side
  input  logic                     i_tx_wr_en,
  input  logic [7:0]               i_tx_din,
  output logic                     o_tx_full,
  input  logic                     i_rx_rd_en,
  output logic [7:0]               o_rx_dout,
  output logic                     o_rx_empty,
  // ip stack, transmit
  output ros2_eth_pkg::ip_tx_hdr_t o_tx_hdr,
  output logic                     o_tx_hdr_valid,
  input  logic                     i_tx_hdr_ready,
  output ros2_eth_pkg::ip_beat_t   o_tx_payload,
  output logic                     o_tx_payload_valid,
  input  logic                     i_tx_payload_ready,
  // ip stack, receive
  input  ros2_eth_pkg::ip_rx_hdr_t i_rx_hdr,
  input  logic                     i_rx_hdr_valid,
  output logic                     o_rx_hdr_ready,
  input  ros2_eth_pkg::ip_beat_t   i_rx_payload,
  input  logic                     i_rx_payload_valid,
  output logic                     o_rx_payload_ready,
  // buffer grants
  input  logic                     i_app_data_ip_req,
  input  logic                     i_app_data_ip_rel,
  output logic                     o_app_data_ip_grant,
  input  logic                     i_app_data_cpu_req,
  input  logic                     i_app_data_cpu_rel,
  output logic                     o_app_data_cpu_grant,
  input  logic                     i_app_rx_ip_rel,
  output logic                     o_app_rx_ip_grant,
  input  logic                     i_app_rx_cpu_rel,
  output logic                     o_app_rx_cpu_grant
);

  logic [7:0] tx_q_dout;
  logic       tx_q_empty;
  logic       tx_q_rd_en;
  logic [7:0] rx_q_din;
  logic       rx_q_full;
  logic       rx_q_wr_en;

  // ######################################################################
  // transmit path, core bytes to ip header and beats
  // ######################################################################
  byte_queue #(.DEPTH(`ROS2_ETH_TX_DEPTH)) u_tx_queue (
    .clk(clk), .rst_n(rst_n),
    .i_wr_en(i_tx_wr_en), .i_din(i_tx_din), .o_full(o_tx_full),
    .i_rd_en(tx_q_rd_en), .o_dout(tx_q_dout), .o_empty(tx_q_empty)
  );

  ros2_eth_tx_adapter u_tx_adapter (
    .clk(clk), .rst_n(rst_n), .i_enable(i_ether_en), .i_local_ip(i_local_ip),
    .i_din(tx_q_dout), .i_din_empty(tx_q_empty), .o_din_rd_en(tx_q_rd_en),
    .o_tx_hdr(o_tx_hdr), .o_tx_hdr_valid(o_tx_hdr_valid), .i_tx_hdr_ready(i_tx_hdr_ready),
    .o_tx_payload(o_tx_payload), .o_tx_payload_valid(o_tx_payload_valid),
    .i_tx_payload_ready(i_tx_payload_ready)
  );

  // ######################################################################
  // receive path, udp packets framed for the core
  // ######################################################################
  ros2_eth_rx_adapter u_rx_adapter (
    .clk(clk), .rst_n(rst_n), .i_enable(i_ether_en),
    .i_rx_hdr(i_rx_hdr), .i_rx_hdr_valid(i_rx_hdr_valid), .o_rx_hdr_ready(o_rx_hdr_ready),
    .i_rx_payload(i_rx_payload), .i_rx_payload_valid(i_rx_payload_valid),
    .o_rx_payload_ready(o_rx_payload_ready),
    .o_dout(rx_q_din), .i_dout_full(rx_q_full), .o_dout_wr_en(rx_q_wr_en)
  );

  byte_queue #(.DEPTH(`ROS2_ETH_RX_DEPTH)) u_rx_queue (
    .clk(clk), .rst_n(rst_n),
    .i_wr_en(rx_q_wr_en), .i_din(rx_q_din), .o_full(rx_q_full),
    .i_rd_en(i_rx_rd_en), .o_dout(o_rx_dout), .o_empty(o_rx_empty)
  );

  // app data and rx data ownership
  buffer_grant_ctrl u_grant_ctrl (
    .clk(clk), .rst_n(rst_n), .i_enable(i_ether_en),
    .i_app_data_ip_req(i_app_data_ip_req), .i_app_data_ip_rel(i_app_data_ip_rel),
    .i_app_data_cpu_req(i_app_data_cpu_req), .i_app_data_cpu_rel(i_app_data_cpu_rel),
    .o_app_data_ip_grant(o_app_data_ip_grant), .o_app_data_cpu_grant(o_app_data_cpu_grant),
    .i_app_rx_ip_rel(i_app_rx_ip_rel), .i_app_rx_cpu_rel(i_app_rx_cpu_rel),
    .o_app_rx_ip_grant(o_app_rx_ip_grant), .o_app_rx_cpu_grant(o_app_rx_cpu_grant)
  );

endmodule

// ==== bench/tb_ros2_eth_bridge.sv ====
`include "ros2_eth_defs.svh"

module tb_ros2_eth_bridge;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 200;
  localparam logic [31:0] LOCAL_IP = 32'hc0a80001;
  localparam logic [15:0] HOLD_LEN = 16'(`ROS2_ETH_TX_DEPTH - `ROS2_ETH_FRAME_HDR_LEN);

  typedef struct packed {
    logic        is_rx;
    logic [31:0] addr;
    logic [15:0] len;
    logic [7:0]  proto;
  } frame_t;

  typedef struct packed {
    logic en;
    logic ip_req;
    logic ip_rel;
    logic cpu_req;
    logic cpu_rel;
    logic rx_ip_rel;
    logic rx_cpu_rel;
    logic exp_ip;
    logic exp_cpu;
    logic exp_rx_ip;
    logic exp_rx_cpu;
  } grant_step_t;

  // tx frames come first and then udp / other / udp on receive
  frame_t frames [7] = '{
    '{1'b0, 32'h0a000001, 16'd0,  8'd17},
    '{1'b0, 32'hc0a80105, 16'd1,  8'd17},
    '{1'b0, 32'hc0a80107, 16'd5,  8'd17},
    '{1'b0, 32'h0a0a0a0a, 16'd10, 8'd17},
    '{1'b1, 32'hc0a80002, 16'd4,  8'd17},
    '{1'b1, 32'hc0a80003, 16'd3,  8'd6},
    '{1'b1, 32'hc0a80004, 16'd8,  8'd17}
  };

  grant_step_t grant_steps [12] = '{
    '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
    '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0},  // core wins tie
    '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
    '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0},
    '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0},
    '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
    '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1},  // rx to cpu
    '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
    '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},  // masked
    '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0},
    '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0}
  };

  logic clk;
  logic rst_n;
  logic i_ether_en;
  logic [31:0] i_local_ip;
  logic i_tx_wr_en;
  logic [7:0] i_tx_din;
  logic o_tx_full;
  logic i_rx_rd_en;
  logic [7:0] o_rx_dout;
  logic o_rx_empty;
  ros2_eth_pkg::ip_tx_hdr_t o_tx_hdr;
  logic o_tx_hdr_valid;
  logic i_tx_hdr_ready;
  ros2_eth_pkg::ip_beat_t o_tx_payload;
  logic o_tx_payload_valid;
  logic i_tx_payload_ready;
  ros2_eth_pkg::ip_rx_hdr_t i_rx_hdr;
  logic i_rx_hdr_valid;
  logic o_rx_hdr_ready;
  ros2_eth_pkg::ip_beat_t i_rx_payload;
  logic i_rx_payload_valid;
  logic o_rx_payload_ready;
  logic i_app_data_ip_req;
  logic i_app_data_ip_rel;
  logic o_app_data_ip_grant;
  logic i_app_data_cpu_req;
  logic i_app_data_cpu_rel;
  logic o_app_data_cpu_grant;
  logic i_app_rx_ip_rel;
  logic o_app_rx_ip_grant;
  logic i_app_rx_cpu_rel;
  logic o_app_rx_cpu_grant;

  logic [31:0] lfsr_state = 32'h07d25993;
  logic [7:0]  payload [16];
  int          mismatches = 0;
  int          timeouts = 0;

  ros2_eth_bridge u_ros2_eth_bridge (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ######################################################################
  // helpers
  // ######################################################################
  function automatic logic take_bit();
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    return lfsr_state[0];
  endfunction

  function automatic logic [7:0] take_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++) b = {b[6:0], take_bit()};
    return b;
  endfunction

  // address and length go msb first ahead of the payload
  function automatic logic [7:0] frame_byte(input logic [31:0] addr, input logic [15:0] len,
                                            input int k);
    if (k < 4) return addr[8*(3-k) +: 8];
    if (k == 4) return len[15:8];
    if (k == 5) return len[7:0];
    return payload[k-6];
  endfunction

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic fill_payload(input logic [15:0] len);
    for (int k = 0; k < int'(len); k++) payload[k] = take_byte();
  endtask

  task automatic write_tx_frame(input logic [31:0] addr, input logic [15:0] len);
    int wait_cnt;
    for (int k = 0; k < int'(len) + `ROS2_ETH_FRAME_HDR_LEN; k++) begin
      wait_cnt = 0;
      @(negedge clk);
      while (o_tx_full && wait_cnt < TIMEOUT) begin
        @(negedge clk);
        wait_cnt++;
      end
      if (o_tx_full) begin
        timeouts++;
        $display("tx queue stayed full at %0t ns", $time);
      end
      @(posedge clk);
      i_tx_wr_en <= 1'b1;
      i_tx_din   <= frame_byte(addr, len, k);
      @(posedge clk);
      i_tx_wr_en <= 1'b0;
    end
  endtask

  task automatic receive_tx(input logic [31:0] addr, input logic [15:0] len);
    int wait_cnt;
    int k;
    logic got;
    wait_cnt = 0;
    got = 1'b0;
    while (!got && wait_cnt < TIMEOUT) begin
      @(posedge clk);
      i_tx_hdr_ready <= take_bit();   // random back-pressure
      @(negedge clk);
      if (o_tx_hdr_valid && i_tx_hdr_ready) begin
        got = 1'b1;
        check_field("o_tx_hdr.dest_ip", o_tx_hdr.dest_ip, addr);
        check_field("o_tx_hdr.source_ip", o_tx_hdr.source_ip, LOCAL_IP);
        check_field("o_tx_hdr.length", 32'(o_tx_hdr.length),
                    32'(len) + `ROS2_ETH_IP_HDR_LEN);
        check_field("o_tx_hdr.protocol", 32'(o_tx_hdr.protocol), `ROS2_ETH_PROTO_UDP);
        check_field("o_tx_hdr.ttl", 32'(o_tx_hdr.ttl), `ROS2_ETH_DEFAULT_TTL);
        check_field("o_tx_hdr.dscp", 32'(o_tx_hdr.dscp), 32'd0);
        check_field("o_tx_hdr.ecn", 32'(o_tx_hdr.ecn), 32'd0);
      end
      wait_cnt++;
    end
    @(posedge clk);
    i_tx_hdr_ready <= 1'b0;
    if (!got) begin
      timeouts++;
      $display("no tx header seen for frame to 0x%0h", addr);
    end
    k = 0;
    wait_cnt = 0;
    while (k < int'(len) && wait_cnt < TIMEOUT) begin
      @(posedge clk);
      i_tx_payload_ready <= take_bit();
      @(negedge clk);
      if (o_tx_payload_valid && i_tx_payload_ready) begin
        check_field("o_tx_payload.data", 32'(o_tx_payload.data), 32'(payload[k]));
        check_field("o_tx_payload.last", 32'(o_tx_payload.last), 32'(k == int'(len) - 1));
        k++;
        wait_cnt = 0;
      end else begin
        wait_cnt++;
      end
    end
    @(posedge clk);
    i_tx_payload_ready <= 1'b0;
    if (k < int'(len)) begin
      timeouts++;
      $display("tx payload stopped after %0d of %0d bytes", k, len);
    end
  endtask

  task automatic send_rx_packet(input logic [31:0] addr, input logic [15:0] len,
                                input logic [7:0] proto);
    ros2_eth_pkg::ip_rx_hdr_t h;
    int wait_cnt;
    h.source_ip = addr;
    h.dest_ip   = LOCAL_IP;
    h.length    = len + 16'(`ROS2_ETH_IP_HDR_LEN);
    h.protocol  = proto;
    h.ttl       = 8'(`ROS2_ETH_DEFAULT_TTL);
    @(posedge clk);
    i_rx_hdr       <= h;
    i_rx_hdr_valid <= 1'b1;
    wait_cnt = 0;
    @(negedge clk);
    while (!o_rx_hdr_ready && wait_cnt < TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!o_rx_hdr_ready) begin
      timeouts++;
      $display("rx header never accepted at %0t ns", $time);
    end
    @(posedge clk);
    i_rx_hdr_valid <= 1'b0;
    for (int k = 0; k < int'(len); k++) begin
      if (k > 0) @(posedge clk);
      i_rx_payload       <= '{data: payload[k], last: (k == int'(len) - 1)};
      i_rx_payload_valid <= 1'b1;
      wait_cnt = 0;
      @(negedge clk);
      while (!o_rx_payload_ready && wait_cnt < TIMEOUT) begin
        @(negedge clk);
        wait_cnt++;
      end
      if (!o_rx_payload_ready) begin
        timeouts++;
        $display("rx payload byte %0d never accepted", k);
      end
    end
    @(posedge clk);
    i_rx_payload_valid <= 1'b0;
  endtask

  task automatic read_rx_frame(input logic [31:0] addr, input logic [15:0] len);
    int wait_cnt;
    int k;
    k = 0;
    wait_cnt = 0;
    while (k < int'(len) + `ROS2_ETH_FRAME_HDR_LEN && wait_cnt < TIMEOUT) begin
      @(posedge clk);
      i_rx_rd_en <= take_bit();
      @(negedge clk);
      if (!o_rx_empty && i_rx_rd_en) begin
        check_field("o_rx_dout", 32'(o_rx_dout), 32'(frame_byte(addr, len, k)));
        k++;
        wait_cnt = 0;
      end else begin
        wait_cnt++;
      end
    end
    @(posedge clk);
    i_rx_rd_en <= 1'b0;
    if (k < int'(len) + `ROS2_ETH_FRAME_HDR_LEN) begin
      timeouts++;
      $display("rx frame from 0x%0h ended after %0d bytes", addr, k);
    end
  endtask

  // ######################################################################
  // test sequence
  // ######################################################################
  initial begin
    rst_n = 1'b0;
    i_ether_en = 1'b1;
    i_local_ip = LOCAL_IP;
    i_tx_wr_en = 1'b0;
    i_tx_din = '0;
    i_rx_rd_en = 1'b0;
    i_tx_hdr_ready = 1'b0;
    i_tx_payload_ready = 1'b0;
    i_rx_hdr = '0;
    i_rx_hdr_valid = 1'b0;
    i_rx_payload = '0;
    i_rx_payload_valid = 1'b0;
    i_app_data_ip_req = 1'b0;
    i_app_data_ip_rel = 1'b0;
    i_app_data_cpu_req = 1'b0;
    i_app_data_cpu_rel = 1'b0;
    i_app_rx_ip_rel = 1'b0;
    i_app_rx_cpu_rel = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_field("o_tx_hdr_valid", 32'(o_tx_hdr_valid), 32'd0);
    check_field("o_tx_payload_valid", 32'(o_tx_payload_valid), 32'd0);
    check_field("o_app_data_ip_grant", 32'(o_app_data_ip_grant), 32'd0);
    check_field("o_app_data_cpu_grant", 32'(o_app_data_cpu_grant), 32'd0);
    check_field("o_app_rx_cpu_grant", 32'(o_app_rx_cpu_grant), 32'd0);
    check_field("o_app_rx_ip_grant", 32'(o_app_rx_ip_grant), 32'd1);

    // each grant step is checked one cycle after its pulse
    foreach (grant_steps[i]) begin
      @(posedge clk);
      i_ether_en         <= grant_steps[i].en;
      i_app_data_ip_req  <= grant_steps[i].ip_req;
      i_app_data_ip_rel  <= grant_steps[i].ip_rel;
      i_app_data_cpu_req <= grant_steps[i].cpu_req;
      i_app_data_cpu_rel <= grant_steps[i].cpu_rel;
      i_app_rx_ip_rel    <= grant_steps[i].rx_ip_rel;
      i_app_rx_cpu_rel   <= grant_steps[i].rx_cpu_rel;
      @(posedge clk);
      {i_app_data_ip_req, i_app_data_ip_rel, i_app_data_cpu_req} <= 3'b000;
      {i_app_data_cpu_rel, i_app_rx_ip_rel, i_app_rx_cpu_rel} <= 3'b000;
      @(negedge clk);
      check_field("o_app_data_ip_grant", 32'(o_app_data_ip_grant), 32'(grant_steps[i].exp_ip));
      check_field("o_app_data_cpu_grant", 32'(o_app_data_cpu_grant),
                  32'(grant_steps[i].exp_cpu));
      check_field("o_app_rx_ip_grant", 32'(o_app_rx_ip_grant), 32'(grant_steps[i].exp_rx_ip));
      check_field("o_app_rx_cpu_grant", 32'(o_app_rx_cpu_grant),
                  32'(grant_steps[i].exp_rx_cpu));
    end

    foreach (frames[i]) begin
      fill_payload(frames[i].len);
      if (!frames[i].is_rx) begin
        write_tx_frame(frames[i].addr, frames[i].len);
        receive_tx(frames[i].addr, frames[i].len);
      end else begin
        send_rx_packet(frames[i].addr, frames[i].len, frames[i].proto);
        if (frames[i].proto == 8'(`ROS2_ETH_PROTO_UDP)) begin
          read_rx_frame(frames[i].addr, frames[i].len);
        end
      end
      for (int c = 0; c < 10; c++) begin
        @(negedge clk);
        check_field("o_rx_empty", 32'(o_rx_empty), 32'd1);   // nothing left over
      end
    end

    // disabled bridge holds a queued frame back
    // prefix plus payload fills the tx queue to the brim
    @(posedge clk);
    i_ether_en <= 1'b0;
    fill_payload(HOLD_LEN);
    write_tx_frame(32'h0a141e28, HOLD_LEN);
    for (int c = 0; c < 20; c++) begin
      @(negedge clk);
      check_field("o_tx_hdr_valid", 32'(o_tx_hdr_valid), 32'd0);
      check_field("o_tx_full", 32'(o_tx_full), 32'd1);
    end
    @(posedge clk);
    i_ether_en <= 1'b1;
    receive_tx(32'h0a141e28, HOLD_LEN);

    repeat (4) @(posedge clk);
    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+src
src/ros2_eth_pkg.sv
src/byte_queue.sv
src/ros2_eth_tx_adapter.sv
src/ros2_eth_rx_adapter.sv
src/buffer_grant_ctrl.sv
src/ros2_eth_bridge.sv
bench/tb_ros2_eth_bridge.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --timing -Wno-fatal
TOP        ?= tb_ros2_eth_bridge
RTL_TOP    ?= ros2_eth_bridge
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := Result: PASSED

RTL_FILES  := $(filter src/%,$(shell grep -v '^+' $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) +incdir+src --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
